// ==== dv/glb_testdata.txt ====
# T name wmask0 wpar0 wmask1 wpar1 rmask0 rpar0 rmask1 rpar1 | W port addr data
# R port addr expected_data | E port addr expected_empty | F port addr expected_full
T par1_roundtrip 1 1 0 0 1 1 0 0
W 0 0 00001111
W 0 1 00002222
W 0 2 00003333
W 0 3 00004444
R 0 0 00001111
R 0 1 00002222
R 0 2 00003333
R 0 3 00004444
T par2_split c 2 0 0 c 2 0 0
W 0 0 aaaa5555
W 0 1 1234fedc
R 0 0 aaaa5555
R 0 1 1234fedc
T empty_flag 2 1 0 0 2 1 0 0
E 0 0 1
W 0 0 0000beef
W 0 1 0000cafe
R 0 0 0000beef
R 0 1 0000cafe
E 0 2 1
T full_flag 1 1 0 0 1 1 0 0
W 0 0 00000010
W 0 1 00000011
W 0 2 00000012
W 0 3 00000013
W 0 4 00000014
W 0 5 00000015
W 0 6 00000016
W 0 7 00000017
F 0 8 1
R 0 0 00000010
F 0 8 0
T side_by_side 1 1 2 1 1 1 2 1
W 0 0 00000a00
W 1 0 00000b00
W 0 1 00000a01
W 1 1 00000b01
R 1 0 00000b00
R 0 0 00000a00
R 1 1 00000b01
R 0 1 00000a01

// ==== sim.f ====
rtl/glb_pkg.sv
rtl/glb_bank.sv
rtl/glb_wr_ctrl.sv
rtl/glb_rd_ctrl.sv
rtl/glb_bank_xbar.sv
rtl/glb_top.sv
dv/glb_tb_asserts.sv
dv/glb_tb.sv

// ==== Makefile ====
TOP = glb_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o sim_bin
	@out=$$(./obj_dir/sim_bin); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== dv/glb_tb.sv ====
// Testbench for the global buffer: file driven writes, reads and flag checks
`timescale 1ns/1ps

module glb_tb;

    localparam int TIMEOUT = 50;

    logic clk;
    logic rst_n;
    glb_pkg::port_cfg_t [glb_pkg::NUM_WRPORT-1:0]        cfg_wr;
    glb_pkg::port_cfg_t [glb_pkg::NUM_RDPORT-1:0]        cfg_rd;
    logic [glb_pkg::NUM_WRPORT-1:0][glb_pkg::BEAT_W-1:0] wr_dat;
    logic [glb_pkg::NUM_WRPORT-1:0]                      wr_vld;
    logic [glb_pkg::NUM_WRPORT-1:0]                      wr_rdy;
    logic [glb_pkg::NUM_WRPORT-1:0][glb_pkg::ADDR_W-1:0] wr_addr;
    logic [glb_pkg::NUM_WRPORT-1:0]                      wr_full;
    logic [glb_pkg::NUM_RDPORT-1:0][glb_pkg::ADDR_W-1:0] rd_addr;
    logic [glb_pkg::NUM_RDPORT-1:0]                      rd_avld;
    logic [glb_pkg::NUM_RDPORT-1:0]                      rd_ardy;
    logic [glb_pkg::NUM_RDPORT-1:0][glb_pkg::BEAT_W-1:0] rd_dat;
    logic [glb_pkg::NUM_RDPORT-1:0]                      rd_dvld;
    logic [glb_pkg::NUM_RDPORT-1:0]                      rd_drdy;
    logic [glb_pkg::NUM_RDPORT-1:0]                      rd_empty;

    logic [31:0] seed;
    string       test_name;
    int          errs;
    int          n_ok;
    int          n_bad;
    bit          in_test;
    bit          aborted;

    glb_top dut0 (
        .clk (clk), .rst_n (rst_n), .cfg_wr_i (cfg_wr), .cfg_rd_i (cfg_rd),
        .wr_dat_i (wr_dat), .wr_vld_i (wr_vld), .wr_rdy_o (wr_rdy),
        .wr_addr_i (wr_addr), .wr_full_o (wr_full),
        .rd_addr_i (rd_addr), .rd_addr_vld_i (rd_avld), .rd_addr_rdy_o (rd_ardy),
        .rd_dat_o (rd_dat), .rd_dat_vld_o (rd_dvld), .rd_dat_rdy_i (rd_drdy),
        .rd_empty_o (rd_empty)
    );

    bind glb_top glb_tb_asserts u_asserts (
        .clk (clk), .rst_n (rst_n), .wr_vld_i (wr_vld_i), .wr_rdy_o (wr_rdy_o),
        .rd_addr_vld_i (rd_addr_vld_i), .rd_addr_rdy_o (rd_addr_rdy_o),
        .rd_dat_vld_o (rd_dat_vld_o), .rd_dat_rdy_i (rd_dat_rdy_i), .rd_dat_o (rd_dat_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            errs++;
        end
    endtask

    task automatic stop_run(input string msg);
        $display("%s: %s", test_name, msg);
        errs++;
        aborted = 1'b1;
    endtask

    // ==============================
    // Port transactions
    // ==============================
    task automatic do_write(input int p, input logic [7:0] a, input logic [31:0] d);
        int cnt;
        cnt = 0;
        wr_addr[p] = a;
        wr_dat[p]  = d;
        wr_vld[p]  = 1'b1;
        #1;
        while (!wr_rdy[p] && cnt < TIMEOUT) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        if (!wr_rdy[p]) stop_run($sformatf("write port %0d never became ready", p));
        @(negedge clk);
        wr_vld[p] = 1'b0;
    endtask

    task automatic do_read(input int p, input logic [7:0] a, input logic [31:0] exp);
        int          cnt;
        logic [31:0] held;
        bit          seen;
        bit          done;
        cnt  = 0;
        seen = 1'b0;
        done = 1'b0;
        held = '0;
        rd_addr[p] = a;
        rd_avld[p] = 1'b1;
        #1;
        while (!rd_ardy[p] && cnt < TIMEOUT) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        if (!rd_ardy[p]) begin
            stop_run($sformatf("read port %0d never accepted address %0d", p, a));
            @(negedge clk);
            rd_avld[p] = 1'b0;
            return;
        end
        @(negedge clk);
        rd_avld[p] = 1'b0;
        cnt = 0;
        // Data ready withheld on about one cycle in four
        while (!done && cnt < TIMEOUT) begin
            seed = xorshift32(seed);
            rd_drdy[p] = seed[0] | seed[1];
            #1;
            if (rd_dvld[p]) begin
                if (seen) check_val("held data", held, rd_dat[p]);
                // A held beat blocks further addresses
                if (!rd_drdy[p]) check_val("rd_addr_rdy_o while held", '0, 32'(rd_ardy[p]));
                held = rd_dat[p];
                seen = 1'b1;
                done = rd_drdy[p];
            end
            @(negedge clk);
            cnt++;
        end
        rd_drdy[p] = 1'b0;
        if (!done) begin
            stop_run($sformatf("read port %0d never returned data for address %0d", p, a));
        end else begin
            check_val($sformatf("read addr %0d", a), exp, held);
            #1;
            check_val("valid after accept", '0, 32'(rd_dvld[p]));
            @(negedge clk);
        end
    endtask

    task automatic check_flag(input string kind, input int p, input logic [7:0] a,
                              input logic exp);
        if (kind == "E") begin
            rd_addr[p] = a;
            #1;
            check_val("rd_empty_o", 32'(exp), 32'(rd_empty[p]));
            if (exp) check_val("rd_addr_rdy_o", '0, 32'(rd_ardy[p]));
        end else begin
            wr_addr[p] = a;
            #1;
            check_val("wr_full_o", 32'(exp), 32'(wr_full[p]));
            if (exp) check_val("wr_rdy_o", '0, 32'(wr_rdy[p]));
        end
        @(negedge clk);
    endtask

    // ==============================
    // Test bookkeeping
    // ==============================
    task automatic finish_test();
        if (in_test) begin
            if (errs == 0) begin
                n_ok++;
                $display("PASS %s", test_name);
            end else begin
                n_bad++;
                $display("FAIL %s (%0d errors)", test_name, errs);
            end
        end
        in_test = 1'b0;
    endtask

    // Reset with ports unallocated, then apply the new configuration
    task automatic start_test(input string name, input logic [15:0] w, input logic [15:0] r);
        finish_test();
        test_name = name;
        errs      = 0;
        in_test   = 1'b1;
        cfg_wr    = '0;
        cfg_rd    = '0;
        rst_n     = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        cfg_wr[0] = '{bank_mask: w[11:8], par: w[13:12]};
        cfg_wr[1] = '{bank_mask: w[3:0],  par: w[5:4]};
        cfg_rd[0] = '{bank_mask: r[11:8], par: r[13:12]};
        cfg_rd[1] = '{bank_mask: r[3:0],  par: r[5:4]};
        @(negedge clk);
    endtask

    initial begin
        int          fd;
        int          rc;
        int          p;
        string       tok;
        string       line;
        logic [3:0]  m[4];
        logic [1:0]  pr[4];
        logic [7:0]  a;
        logic [31:0] d;
        clk = 1'b0;
        rst_n = 1'b0;
        cfg_wr = '0;
        cfg_rd = '0;
        wr_dat = '0;
        wr_vld = '0;
        wr_addr = '0;
        rd_addr = '0;
        rd_avld = '0;
        rd_drdy = '0;
        seed = 32'hec41db66;
        errs = 0;
        n_ok = 0;
        n_bad = 0;
        in_test = 1'b0;
        aborted = 1'b0;
        test_name = "setup";
        fd = $fopen("dv/glb_testdata.txt", "r");
        if (fd == 0) stop_run("test data file could not be opened");
        while (!aborted && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                rc = $fgets(line, fd);
            end else if (tok == "T") begin
                rc = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", line,
                             m[0], pr[0], m[1], pr[1], m[2], pr[2], m[3], pr[3]);
                start_test(line, {2'b0, pr[0], m[0], 2'b0, pr[1], m[1]},
                           {2'b0, pr[2], m[2], 2'b0, pr[3], m[3]});
            end else if (tok == "W" || tok == "R" || tok == "E" || tok == "F") begin
                rc = $fscanf(fd, "%d %h %h", p, a, d);
                if (tok == "W") do_write(p, a, d);
                else if (tok == "R") do_read(p, a, d);
                else check_flag(tok, p, a, d[0]);
            end else begin
                stop_run($sformatf("unknown record %s in test data", tok));
            end
        end
        finish_test();
        if (fd != 0) $fclose(fd);
        $display("Tests: %0d passed, %0d failed", n_ok, n_bad);
        if (n_bad == 0 && !aborted) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dv/glb_tb_asserts.sv ====
// Concurrent handshake and reset checks bound to the global buffer top
`timescale 1ns/1ps

module glb_tb_asserts (
    input logic                                                clk,
    input logic                                                rst_n,
    input logic [glb_pkg::NUM_WRPORT-1:0]                      wr_vld_i,
    input logic [glb_pkg::NUM_WRPORT-1:0]                      wr_rdy_o,
    input logic [glb_pkg::NUM_RDPORT-1:0]                      rd_addr_vld_i,
    input logic [glb_pkg::NUM_RDPORT-1:0]                      rd_addr_rdy_o,
    input logic [glb_pkg::NUM_RDPORT-1:0]                      rd_dat_vld_o,
    input logic [glb_pkg::NUM_RDPORT-1:0]                      rd_dat_rdy_i,
    input logic [glb_pkg::NUM_RDPORT-1:0][glb_pkg::BEAT_W-1:0] rd_dat_o
);

    for (genvar p = 0; p < glb_pkg::NUM_WRPORT; p++) begin : g_wr
        a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
            wr_vld_i[p] && !wr_rdy_o[p] |=> wr_vld_i[p])
            else $error("write valid dropped before acceptance on port %0d", p);
    end

    for (genvar p = 0; p < glb_pkg::NUM_RDPORT; p++) begin : g_rd
        a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
            rd_addr_vld_i[p] && !rd_addr_rdy_o[p] |=> rd_addr_vld_i[p])
            else $error("read address valid dropped before acceptance on port %0d", p);

        // Held beat must not change while it waits
        a_dat_stable: assert property (@(posedge clk) disable iff (!rst_n)
            rd_dat_vld_o[p] && !rd_dat_rdy_i[p] |=> rd_dat_vld_o[p] && $stable(rd_dat_o[p]))
            else $error("read data changed or vanished before acceptance on port %0d", p);
    end

    a_no_rdy_in_rst: assert property (@(posedge clk)
        !rst_n |-> (wr_rdy_o == '0) && (rd_addr_rdy_o == '0))
        else $error("ready output high during reset");

endmodule

// ==== rtl/glb_top.sv ====
// Global buffer top: write controller, read controller and bank crossbar
`timescale 1ns/1ps

module glb_top (
    input  logic                                                clk,
    input  logic                                                rst_n,
    // Configuration, static during traffic
    input  glb_pkg::port_cfg_t [glb_pkg::NUM_WRPORT-1:0]        cfg_wr_i,
    input  glb_pkg::port_cfg_t [glb_pkg::NUM_RDPORT-1:0]        cfg_rd_i,
    // Write ports
    input  logic [glb_pkg::NUM_WRPORT-1:0][glb_pkg::BEAT_W-1:0] wr_dat_i,
    input  logic [glb_pkg::NUM_WRPORT-1:0]                      wr_vld_i,
    output logic [glb_pkg::NUM_WRPORT-1:0]                      wr_rdy_o,
    input  logic [glb_pkg::NUM_WRPORT-1:0][glb_pkg::ADDR_W-1:0] wr_addr_i,
    output logic [glb_pkg::NUM_WRPORT-1:0]                      wr_full_o,
    // Read address
    input  logic [glb_pkg::NUM_RDPORT-1:0][glb_pkg::ADDR_W-1:0] rd_addr_i,
    input  logic [glb_pkg::NUM_RDPORT-1:0]                      rd_addr_vld_i,
    output logic [glb_pkg::NUM_RDPORT-1:0]                      rd_addr_rdy_o,
    // Read data
    output logic [glb_pkg::NUM_RDPORT-1:0][glb_pkg::BEAT_W-1:0] rd_dat_o,
    output logic [glb_pkg::NUM_RDPORT-1:0]                      rd_dat_vld_o,
    input  logic [glb_pkg::NUM_RDPORT-1:0]                      rd_dat_rdy_i,
    output logic [glb_pkg::NUM_RDPORT-1:0]                      rd_empty_o
);

    glb_pkg::wr_req_t    [glb_pkg::NUM_WRPORT-1:0] wr_req;
    glb_pkg::rd_req_t    [glb_pkg::NUM_RDPORT-1:0] rd_req;
    glb_pkg::bank_stat_t [glb_pkg::NUM_BANK-1:0]   stat;

    glb_wr_ctrl u_wr_ctrl (
        .cfg_i     (cfg_wr_i),
        .wr_addr_i (wr_addr_i),
        .wr_dat_i  (wr_dat_i),
        .wr_vld_i  (wr_vld_i),
        .stat_i    (stat),
        .wr_req_o  (wr_req),
        .wr_rdy_o  (wr_rdy_o),
        .wr_full_o (wr_full_o)
    );

    glb_rd_ctrl u_rd_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_i         (cfg_rd_i),
        .rd_addr_i     (rd_addr_i),
        .rd_addr_vld_i (rd_addr_vld_i),
        .rd_dat_rdy_i  (rd_dat_rdy_i),
        .stat_i        (stat),
        .rd_req_o      (rd_req),
        .rd_addr_rdy_o (rd_addr_rdy_o),
        .rd_dat_o      (rd_dat_o),
        .rd_dat_vld_o  (rd_dat_vld_o),
        .rd_empty_o    (rd_empty_o)
    );

    glb_bank_xbar u_bank_xbar (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_wr_i (cfg_wr_i),
        .cfg_rd_i (cfg_rd_i),
        .wr_req_i (wr_req),
        .rd_req_i (rd_req),
        .stat_o   (stat)
    );

endmodule

// ==== rtl/glb_bank_xbar.sv ====
// Bank crossbar: port select per bank, bank instances, write and read marks, status
`timescale 1ns/1ps

module glb_bank_xbar (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  glb_pkg::port_cfg_t  [glb_pkg::NUM_WRPORT-1:0]   cfg_wr_i,
    input  glb_pkg::port_cfg_t  [glb_pkg::NUM_RDPORT-1:0]   cfg_rd_i,
    input  glb_pkg::wr_req_t    [glb_pkg::NUM_WRPORT-1:0]   wr_req_i,
    input  glb_pkg::rd_req_t    [glb_pkg::NUM_RDPORT-1:0]   rd_req_i,
    output glb_pkg::bank_stat_t [glb_pkg::NUM_BANK-1:0]     stat_o
);

    for (genvar b = 0; b < glb_pkg::NUM_BANK; b++) begin : g_bank
        glb_pkg::wr_req_t           wsel;
        glb_pkg::rd_req_t           rsel;
        logic [glb_pkg::RANK_W-1:0] rank;
        logic                       wvalid;
        logic                       wready;
        logic [glb_pkg::WORD_W-1:0] wdata;
        logic                       arvalid;
        logic                       arready;
        logic                       rvalid;
        logic                       rready;
        logic [glb_pkg::WORD_W-1:0] rdata;
        logic [glb_pkg::ADDR_W-1:0] wr_mark;
        logic [glb_pkg::ADDR_W-1:0] rd_mark;

        // ==============================
        // Owner select
        // ==============================
        // Lowest port index wins when masks overlap
        always_comb begin
            wsel = '0;
            for (int p = glb_pkg::NUM_WRPORT - 1; p >= 0; p--) begin
                if (cfg_wr_i[p].bank_mask[b]) wsel = wr_req_i[p];
            end
        end

        always_comb begin
            rsel = '0;
            for (int p = glb_pkg::NUM_RDPORT - 1; p >= 0; p--) begin
                if (cfg_rd_i[p].bank_mask[b]) rsel = rd_req_i[p];
            end
        end

        // Position of this bank among the hit banks picks the beat slice
        always_comb begin
            rank = '0;
            for (int i = 0; i < b; i++) begin
                if (wsel.hit[i]) rank = rank + glb_pkg::RANK_W'(1);
            end
        end

        assign wvalid  = wsel.valid & wsel.hit[b];
        assign wdata   = wsel.data[glb_pkg::WORD_W*rank +: glb_pkg::WORD_W];
        assign arvalid = rsel.valid & rsel.hit[b];
        assign rready  = rsel.dat_rdy;

        glb_bank u_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .wvalid_i  (wvalid),
            .wready_o  (wready),
            .waddr_i   (wsel.addr[glb_pkg::DEPTH_W-1:0]),
            .wdata_i   (wdata),
            .arvalid_i (arvalid),
            .arready_o (arready),
            .araddr_i  (rsel.addr[glb_pkg::DEPTH_W-1:0]),
            .rvalid_o  (rvalid),
            .rready_i  (rready),
            .rdata_o   (rdata)
        );

        // ==============================
        // Address marks
        // ==============================
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_mark <= '0;
            end else if (wvalid & wready) begin
                wr_mark <= wsel.addr + 1'b1;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rd_mark <= '0;
            end else if (arvalid & arready) begin
                rd_mark <= rsel.addr + 1'b1;
            end
        end

        assign stat_o[b] = '{
            wready:  wready,
            arready: arready,
            rvalid:  rvalid,
            rdata:   rdata,
            wr_mark: wr_mark,
            rd_mark: rd_mark
        };
    end

endmodule

// ==== rtl/glb_rd_ctrl.sv ====
// Read port controller: bank mapping, address ready, empty flag and read data return
`timescale 1ns/1ps

module glb_rd_ctrl (
    input  logic                                                             clk,
    input  logic                                                             rst_n,
    input  glb_pkg::port_cfg_t  [glb_pkg::NUM_RDPORT-1:0]                    cfg_i,
    input  logic [glb_pkg::NUM_RDPORT-1:0][glb_pkg::ADDR_W-1:0]              rd_addr_i,
    input  logic [glb_pkg::NUM_RDPORT-1:0]                                   rd_addr_vld_i,
    input  logic [glb_pkg::NUM_RDPORT-1:0]                                   rd_dat_rdy_i,
    input  glb_pkg::bank_stat_t [glb_pkg::NUM_BANK-1:0]                      stat_i,
    output glb_pkg::rd_req_t    [glb_pkg::NUM_RDPORT-1:0]                    rd_req_o,
    output logic [glb_pkg::NUM_RDPORT-1:0]                                   rd_addr_rdy_o,
    output logic [glb_pkg::NUM_RDPORT-1:0][glb_pkg::BEAT_W-1:0]              rd_dat_o,
    output logic [glb_pkg::NUM_RDPORT-1:0]                                   rd_dat_vld_o,
    output logic [glb_pkg::NUM_RDPORT-1:0]                                   rd_empty_o
);

    for (genvar p = 0; p < glb_pkg::NUM_RDPORT; p++) begin : g_port
        logic [glb_pkg::BIDX_W-1:0] cur;
        logic [glb_pkg::BIDX_W-1:0] cur_q;
        logic [glb_pkg::BIDX_W-1:0] idx;
        logic [glb_pkg::BEAT_W-1:0] dat;
        logic                       alloc;
        logic                       empty;
        logic                       stall;

        // ==============================
        // Address side
        // ==============================
        assign alloc = |cfg_i[p].bank_mask;
        assign cur   = glb_pkg::cur_first(cfg_i[p], rd_addr_i[p]);
        assign empty = rd_addr_i[p] >= stat_i[cur].wr_mark;

        // Hold new addresses while the previous beat waits, even in another group
        assign stall = rd_dat_vld_o[p] & ~rd_dat_rdy_i[p];

        assign rd_empty_o[p]    = empty;
        assign rd_addr_rdy_o[p] = alloc & ~empty & stat_i[cur].arready & ~stall;

        assign rd_req_o[p].hit     = glb_pkg::hit_mask(cfg_i[p], cur);
        assign rd_req_o[p].valid   = rd_addr_vld_i[p] & rd_addr_rdy_o[p];
        assign rd_req_o[p].addr    = rd_addr_i[p];
        assign rd_req_o[p].dat_rdy = rd_dat_rdy_i[p];

        // Group of the outstanding read, kept after the address moves on
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cur_q <= '0;
            end else if (rd_req_o[p].valid) begin
                cur_q <= cur;
            end
        end

        // ==============================
        // Data side
        // ==============================
        always_comb begin
            dat = '0;
            idx = cur_q;
            for (int k = 0; k < glb_pkg::MAXPAR; k++) begin
                idx = cur_q + glb_pkg::BIDX_W'(k);
                // Unused upper slices read as zero
                if (k < int'(cfg_i[p].par)) begin
                    dat[glb_pkg::WORD_W*k +: glb_pkg::WORD_W] = stat_i[idx].rdata;
                end
            end
        end

        assign rd_dat_o[p]     = dat;
        assign rd_dat_vld_o[p] = alloc & stat_i[cur_q].rvalid;
    end

endmodule

// ==== rtl/glb_wr_ctrl.sv ====
// Write port controller: bank mapping, write ready and full flag
`timescale 1ns/1ps

module glb_wr_ctrl (
    input  glb_pkg::port_cfg_t  [glb_pkg::NUM_WRPORT-1:0]                    cfg_i,
    input  logic [glb_pkg::NUM_WRPORT-1:0][glb_pkg::ADDR_W-1:0]              wr_addr_i,
    input  logic [glb_pkg::NUM_WRPORT-1:0][glb_pkg::BEAT_W-1:0]              wr_dat_i,
    input  logic [glb_pkg::NUM_WRPORT-1:0]                                   wr_vld_i,
    input  glb_pkg::bank_stat_t [glb_pkg::NUM_BANK-1:0]                      stat_i,
    output glb_pkg::wr_req_t    [glb_pkg::NUM_WRPORT-1:0]                    wr_req_o,
    output logic [glb_pkg::NUM_WRPORT-1:0]                                   wr_rdy_o,
    output logic [glb_pkg::NUM_WRPORT-1:0]                                   wr_full_o
);

    for (genvar p = 0; p < glb_pkg::NUM_WRPORT; p++) begin : g_port
        logic [glb_pkg::BIDX_W-1:0] cur;
        logic [glb_pkg::ADDR_W-1:0] space;
        logic [glb_pkg::ADDR_W-1:0] ahead;
        logic                       alloc;
        logic                       full;

        // ==============================
        // Ring mapping
        // ==============================
        assign alloc = |cfg_i[p].bank_mask;
        assign space = glb_pkg::port_space(cfg_i[p]);
        assign cur   = glb_pkg::cur_first(cfg_i[p], wr_addr_i[p]);

        // Distance of the writer in front of the reader, modulo the address range
        assign ahead = wr_addr_i[p] - stat_i[cur].rd_mark;
        assign full  = ahead >= space;

        assign wr_full_o[p] = full;
        assign wr_rdy_o[p]  = alloc & ~full & stat_i[cur].wready;

        // ==============================
        // Request toward the banks
        // ==============================
        assign wr_req_o[p].hit   = glb_pkg::hit_mask(cfg_i[p], cur);
        assign wr_req_o[p].valid = wr_vld_i[p] & wr_rdy_o[p];
        assign wr_req_o[p].addr  = wr_addr_i[p];
        assign wr_req_o[p].data  = wr_dat_i[p];
    end

endmodule

// ==== rtl/glb_bank.sv ====
// SRAM bank model with separate write and read channels and held read data
`timescale 1ns/1ps

module glb_bank (
    input  logic                       clk,
    input  logic                       rst_n,
    // Write channel
    input  logic                       wvalid_i,
    output logic                       wready_o,
    input  logic [glb_pkg::DEPTH_W-1:0] waddr_i,
    input  logic [glb_pkg::WORD_W-1:0]  wdata_i,
    // Read address channel
    input  logic                       arvalid_i,
    output logic                       arready_o,
    input  logic [glb_pkg::DEPTH_W-1:0] araddr_i,
    // Read data channel
    output logic                       rvalid_o,
    input  logic                       rready_i,
    output logic [glb_pkg::WORD_W-1:0]  rdata_o
);

    logic [glb_pkg::WORD_W-1:0] mem [glb_pkg::BANK_DEPTH];
    logic                       rd_fire;

    // Writes never stall
    assign wready_o  = 1'b1;
    // Blocked only while data sits unreturned
    assign arready_o = ~rvalid_o | rready_i;
    assign rd_fire   = arvalid_i & arready_o;

    always_ff @(posedge clk) begin
        if (wvalid_i & wready_o) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_o <= mem[araddr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else if (rd_fire) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

endmodule

// ==== rtl/glb_pkg.sv ====
// Global buffer sizes, port configuration, bank request and status types, mapping functions
package glb_pkg;

    localparam int NUM_BANK   = 4;
    localparam int BANK_DEPTH = 8;
    localparam int DEPTH_W    = 3;
    localparam int WORD_W     = 16;
    localparam int MAXPAR     = 2;
    localparam int BEAT_W     = WORD_W * MAXPAR;
    localparam int NUM_WRPORT = 2;
    localparam int NUM_RDPORT = 2;
    localparam int ADDR_W     = 8;
    localparam int BIDX_W     = 2;
    localparam int PAR_W      = 2;
    // Rank of a bank inside one beat
    localparam int RANK_W     = $clog2(MAXPAR);

    typedef struct packed {
        logic [NUM_BANK-1:0] bank_mask;
        logic [PAR_W-1:0]    par;
    } port_cfg_t;

    typedef struct packed {
        logic [NUM_BANK-1:0] hit;
        logic                valid;
        logic [ADDR_W-1:0]   addr;
        logic [BEAT_W-1:0]   data;
    } wr_req_t;

    typedef struct packed {
        logic [NUM_BANK-1:0] hit;
        logic                valid;
        logic [ADDR_W-1:0]   addr;
        logic                dat_rdy;
    } rd_req_t;

    typedef struct packed {
        logic              wready;
        logic              arready;
        logic              rvalid;
        logic [WORD_W-1:0] rdata;
        logic [ADDR_W-1:0] wr_mark;
        logic [ADDR_W-1:0] rd_mark;
    } bank_stat_t;

    // ==============================
    // Address to bank mapping
    // ==============================

    // Lowest set bit of the mask
    function automatic logic [BIDX_W-1:0] first_bank(input logic [NUM_BANK-1:0] mask);
        first_bank = '0;
        for (int b = NUM_BANK - 1; b >= 0; b--) begin
            if (mask[b]) first_bank = BIDX_W'(b);
        end
    endfunction

    // Words addressable before the ring wraps
    function automatic logic [ADDR_W-1:0] port_space(input port_cfg_t cfg);
        int nbank;
        nbank = $countones(cfg.bank_mask);
        if (cfg.par == '0 || nbank == 0) return ADDR_W'(BANK_DEPTH);
        return ADDR_W'((BANK_DEPTH * nbank) / int'(cfg.par));
    endfunction

    function automatic logic [BIDX_W-1:0] cur_first(input port_cfg_t cfg,
                                                    input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] space;
        space = port_space(cfg);
        return BIDX_W'(int'(first_bank(cfg.bank_mask)) +
                       int'(cfg.par) * int'((addr % space) / BANK_DEPTH));
    endfunction

    // par banks starting at the current first bank
    function automatic logic [NUM_BANK-1:0] hit_mask(input port_cfg_t cfg,
                                                    input logic [BIDX_W-1:0] cur);
        hit_mask = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            hit_mask[b] = (b >= int'(cur)) && (b < int'(cur) + int'(cfg.par));
        end
        hit_mask = hit_mask & {NUM_BANK{|cfg.bank_mask}};
    endfunction

endpackage
